//--- source/bram_loader_pkg.sv
`default_nettype none

package bram_loader_pkg;

    // Stream and bank geometry
    localparam int DATA_WIDTH      = 16;
    localparam int OPCODE_WIDTH    = 8;
    localparam int BANK_ID_WIDTH   = 5;
    localparam int WORD_ADDR_WIDTH = 16;
    localparam int NUM_BANKS       = 32;                 // Covers every 5-bit bank id
    localparam int BANK_DEPTH      = 64;
    localparam int BANK_ADDR_WIDTH = $clog2(BANK_DEPTH);

    // Header constants
    localparam logic [DATA_WIDTH-1:0]   HEADER_MAGIC = 16'hC0DE;
    localparam logic [OPCODE_WIDTH-1:0] OP_LOAD      = 8'h01;

    typedef logic [DATA_WIDTH-1:0]      data_word_t;
    typedef logic [OPCODE_WIDTH-1:0]    opcode_t;
    typedef logic [BANK_ID_WIDTH-1:0]   bank_id_t;
    typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;
    typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;  // Low bits of a header address

    // One state per header word, then payload
    typedef enum logic [2:0] {
        HEADER_0  = 3'd0,  // Magic
        HEADER_1  = 3'd1,  // Instruction
        HEADER_2  = 3'd2,  // First bank
        HEADER_3  = 3'd3,  // Last bank
        HEADER_4  = 3'd4,  // Start address
        HEADER_5  = 3'd5,  // Per-bank count
        DATA_PASS = 3'd6
    } parser_state_t;

    typedef struct packed {
        data_word_t data;
        logic       last;
    } stream_beat_t;

    typedef struct packed {
        opcode_t    instruction;
        bank_id_t   bram_start;
        bank_id_t   bram_end;
        word_addr_t addr_start;
        word_addr_t addr_count;
        logic       magic_ok;
    } packet_header_t;

    // Sticky per-packet flags plus write count
    typedef struct packed {
        logic       error_invalid_magic;
        logic       error_bad_opcode;
        logic       overflow;
        logic       packet_done;
        word_addr_t words_written;
    } loader_status_t;

endpackage

`default_nettype wire

//--- source/axi_header_parser.sv
`default_nettype none

module axi_header_parser
    import bram_loader_pkg::*;
(
    input  wire            aclk,
    input  wire            aresetn,

    // DMA side
    input  wire            s_valid,
    output logic           s_ready,
    input  stream_beat_t   s_beat,

    // Payload towards the write controller
    output logic           p_valid,
    input  wire            p_ready,
    output stream_beat_t   p_beat,

    // Captured header
    output packet_header_t header,
    output logic           header_valid,

    output parser_state_t  parser_state
);

    parser_state_t state_q;
    parser_state_t state_d;

    logic s_accept;

    // Header words collected while parsing, published all at once
    opcode_t    stage_instruction;
    bank_id_t   stage_bram_start;
    bank_id_t   stage_bram_end;
    word_addr_t stage_addr_start;
    logic       stage_magic_ok;

    assign s_accept     = s_valid && s_ready;
    assign parser_state = state_q;

    // Beat content is forwarded as is, valid is qualified by state
    assign p_beat = s_beat;

    always_comb begin
        state_d = state_q;
        s_ready = 1'b1;  // Header words are always taken
        p_valid = 1'b0;

        case (state_q)
            HEADER_0: begin
                if (s_valid) state_d = HEADER_1;
            end
            HEADER_1: begin
                if (s_valid) state_d = HEADER_2;
            end
            HEADER_2: begin
                if (s_valid) state_d = HEADER_3;
            end
            HEADER_3: begin
                if (s_valid) state_d = HEADER_4;
            end
            HEADER_4: begin
                if (s_valid) state_d = HEADER_5;
            end
            HEADER_5: begin
                if (s_valid) state_d = DATA_PASS;
            end
            DATA_PASS: begin
                s_ready = p_ready;
                p_valid = s_valid;
                // Back to the magic word once the packet ends
                if (s_valid && p_ready && s_beat.last) begin
                    state_d = HEADER_0;
                end
            end
            default: state_d = HEADER_0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q <= HEADER_0;
        end else begin
            state_q <= state_d;
        end
    end

    // Field capture, one word per header state
    always_ff @(posedge aclk) begin
        if (s_accept) begin
            case (state_q)
                HEADER_0: stage_magic_ok    <= (s_beat.data == HEADER_MAGIC);
                HEADER_1: stage_instruction <= s_beat.data[OPCODE_WIDTH-1:0];
                HEADER_2: stage_bram_start  <= s_beat.data[BANK_ID_WIDTH-1:0];
                HEADER_3: stage_bram_end    <= s_beat.data[BANK_ID_WIDTH-1:0];
                HEADER_4: stage_addr_start  <= s_beat.data;
                default: ;
            endcase
        end
    end

    // Whole header updates on the count word so it stays stable per packet
    always_ff @(posedge aclk) begin
        if (s_accept && state_q == HEADER_5) begin
            header.instruction <= stage_instruction;
            header.bram_start  <= stage_bram_start;
            header.bram_end    <= stage_bram_end;
            header.addr_start  <= stage_addr_start;
            header.addr_count  <= s_beat.data;
            header.magic_ok    <= stage_magic_ok;  // Bad magic still parses fully
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            header_valid <= 1'b0;
        end else begin
            header_valid <= s_accept && (state_q == HEADER_5);  // One-cycle pulse
        end
    end

endmodule

`default_nettype wire

//--- source/bank_write_ctrl.sv
`default_nettype none

module bank_write_ctrl
    import bram_loader_pkg::*;
(
    input  wire            aclk,
    input  wire            aresetn,

    input  packet_header_t header,
    input  wire            header_valid,

    input  wire            p_valid,
    output logic           p_ready,
    input  stream_beat_t   p_beat,

    // Write strobe to the bank array
    output logic           wr_en,
    output bank_id_t       wr_bank,
    output bank_addr_t     wr_addr,
    output data_word_t     wr_data,

    output loader_status_t status
);

    bank_id_t   cur_bank;
    bank_addr_t cur_addr;
    word_addr_t remaining;   // Words left in the current bank
    logic       load_en;     // Valid magic and LOAD opcode
    logic       banks_done;  // Past bram_end, or nothing to write

    logic p_accept;
    logic drop;
    logic bank_full;

    // Counters reload during the header_valid cycle
    assign p_ready  = !header_valid;
    assign p_accept = p_valid && p_ready;

    assign wr_en   = p_accept && load_en && !banks_done;
    assign wr_bank = cur_bank;
    assign wr_addr = cur_addr;
    assign wr_data = p_beat.data;

    assign drop      = p_accept && load_en && banks_done;
    assign bank_full = (remaining == word_addr_t'(1));

    // Scatter position
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            cur_bank   <= '0;
            cur_addr   <= '0;
            remaining  <= '0;
            load_en    <= 1'b0;
            banks_done <= 1'b1;
        end else if (header_valid) begin
            cur_bank   <= header.bram_start;
            cur_addr   <= header.addr_start[BANK_ADDR_WIDTH-1:0];
            remaining  <= header.addr_count;
            load_en    <= header.magic_ok && (header.instruction == OP_LOAD);
            banks_done <= (header.addr_count == '0);
        end else if (wr_en) begin
            if (bank_full) begin
                // Next bank restarts at the header start address
                if (cur_bank == header.bram_end) begin
                    banks_done <= 1'b1;
                end else begin
                    cur_bank <= cur_bank + bank_id_t'(1);
                end
                cur_addr  <= header.addr_start[BANK_ADDR_WIDTH-1:0];
                remaining <= header.addr_count;
            end else begin
                cur_addr  <= cur_addr + bank_addr_t'(1);  // Wraps inside the bank
                remaining <= remaining - word_addr_t'(1);
            end
        end
    end

    // Status flags and write count
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            status <= '0;
        end else begin
            status.packet_done <= p_accept && p_beat.last;
            if (header_valid) begin
                status.error_invalid_magic <= !header.magic_ok;
                status.error_bad_opcode    <= (header.instruction != OP_LOAD);
                status.overflow            <= 1'b0;
                status.words_written       <= '0;
            end else begin
                if (drop) status.overflow <= 1'b1;
                if (wr_en) begin
                    status.words_written <= status.words_written + word_addr_t'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/bram_bank_array.sv
`default_nettype none

module bram_bank_array
    import bram_loader_pkg::*;
(
    input  wire        aclk,

    // Write port from the controller
    input  wire        wr_en,
    input  bank_id_t   wr_bank,
    input  bank_addr_t wr_addr,
    input  data_word_t wr_data,

    // Read port for the accelerator
    input  wire        rd_en,
    input  bank_id_t   rd_bank,
    input  bank_addr_t rd_addr,
    output data_word_t rd_data
);

    data_word_t mem [NUM_BANKS][BANK_DEPTH];

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_bank][wr_addr] <= wr_data;
        end
    end

    // One cycle read latency, data holds between reads
    always_ff @(posedge aclk) begin
        if (rd_en) begin
            rd_data <= mem[rd_bank][rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- source/bram_loader_top.sv
`default_nettype none

module bram_loader_top
    import bram_loader_pkg::*;
(
    input  wire            aclk,
    input  wire            aresetn,

    // DMA stream
    input  wire            s_valid,
    output logic           s_ready,
    input  stream_beat_t   s_beat,

    // Bank readback
    input  wire            rd_en,
    input  bank_id_t       rd_bank,
    input  bank_addr_t     rd_addr,
    output data_word_t     rd_data,

    output loader_status_t status,
    output parser_state_t  parser_state
);

    logic           p_valid;
    logic           p_ready;
    stream_beat_t   p_beat;
    packet_header_t header;
    logic           header_valid;

    logic       wr_en;
    bank_id_t   wr_bank;
    bank_addr_t wr_addr;
    data_word_t wr_data;

    axi_header_parser parser_i (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .s_valid      (s_valid),
        .s_ready      (s_ready),
        .s_beat       (s_beat),
        .p_valid      (p_valid),
        .p_ready      (p_ready),
        .p_beat       (p_beat),
        .header       (header),
        .header_valid (header_valid),
        .parser_state (parser_state)
    );

    bank_write_ctrl ctrl_i (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .header       (header),
        .header_valid (header_valid),
        .p_valid      (p_valid),
        .p_ready      (p_ready),
        .p_beat       (p_beat),
        .wr_en        (wr_en),
        .wr_bank      (wr_bank),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .status       (status)
    );

    bram_bank_array banks_i (
        .aclk    (aclk),
        .wr_en   (wr_en),
        .wr_bank (wr_bank),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_bank (rd_bank),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

//--- dv/bram_loader_tb.sv
`default_nettype none

module bram_loader_tb
    import bram_loader_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // Header plus payload beats and one readback per word of each checked bank
    localparam int TOTAL_BEATS = (6 + 10) + (6 + 12) + (6 + 8) + (6 + 8) + (6 + 8)
                               + (6 + 14) + (6 + 12) + (6 + 20) + (6 + 9);
    localparam int TOTAL_READS = BANK_DEPTH * (1 + 3 + 2 + 1 + 2 + 6);
    localparam int CYCLE_LIMIT = 4 * (TOTAL_BEATS + TOTAL_READS) + 200;

    logic           aclk;
    logic           aresetn;
    logic           s_valid;
    logic           s_ready;
    stream_beat_t   s_beat;
    logic           rd_en;
    bank_id_t       rd_bank;
    bank_addr_t     rd_addr;
    data_word_t     rd_data;
    loader_status_t status;
    parser_state_t  parser_state;

    data_word_t shadow [NUM_BANKS][BANK_DEPTH];  // Reference banks left X until written
    data_word_t payload_q [$];
    logic [31:0] rng_state = 32'h91df;
    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int cycles       = 0;

    bram_loader_top dut_i (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .s_valid      (s_valid),
        .s_ready      (s_ready),
        .s_beat       (s_beat),
        .rd_en        (rd_en),
        .rd_bank      (rd_bank),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .status       (status),
        .parser_state (parser_state)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_word(input data_word_t got, input data_word_t exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_status(input loader_status_t got, input loader_status_t exp,
                                input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s status magic/op/ovf/done %b%b%b%b written %0d, %s",
                     $time, what, got.error_invalid_magic, got.error_bad_opcode,
                     got.overflow, got.packet_done, got.words_written, "mismatch");
            $display("   expected magic/op/ovf/done %b%b%b%b written %0d",
                     exp.error_invalid_magic, exp.error_bad_opcode, exp.overflow,
                     exp.packet_done, exp.words_written);
            errors++;
        end
    endtask

    task automatic check_state(input parser_state_t got, input parser_state_t exp,
                               input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s parser state %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic fill_payload(input int n_words);
        payload_q.delete();
        for (int i = 0; i < n_words; i++) begin
            payload_q.push_back(data_word_t'(next_random()));
        end
    endtask

    // Applies the scatter rule to the shadow banks and returns the expected status
    task automatic model_scatter(input data_word_t magic, input opcode_t op,
                                 input bank_id_t first, input bank_id_t last_bank,
                                 input word_addr_t start_addr, input word_addr_t count,
                                 output loader_status_t exp);
        int  bank;
        int  addr;
        int  used;
        bit  writes;
        exp = '0;
        exp.error_invalid_magic = (magic != HEADER_MAGIC);
        exp.error_bad_opcode    = (op != OP_LOAD);
        exp.packet_done         = 1'b1;
        writes = (magic == HEADER_MAGIC) && (op == OP_LOAD);
        bank = first;
        addr = start_addr % BANK_DEPTH;
        used = 0;
        for (int i = 0; i < payload_q.size(); i++) begin
            if (writes) begin
                if (count == 0 || bank > last_bank) begin
                    exp.overflow = 1'b1;  // Dropped beat
                end else begin
                    shadow[bank][addr] = payload_q[i];
                    exp.words_written = exp.words_written + 1;
                    addr = (addr + 1) % BANK_DEPTH;
                    used++;
                    if (used == count) begin
                        bank++;
                        addr = start_addr % BANK_DEPTH;
                        used = 0;
                    end
                end
            end
        end
    endtask

    // Offers one beat from a falling edge and returns on the falling edge after it is taken
    task automatic drive_beat(input data_word_t data, input logic last, input bit gaps);
        int gap;
        if (gaps) begin
            gap = next_random() % 4;
            s_valid = 1'b0;
            repeat (gap) @(negedge aclk);
        end
        s_valid     = 1'b1;
        s_beat.data = data;
        s_beat.last = last;
        while (!s_ready) @(negedge aclk);  // Held through the load cycle
        @(negedge aclk);
        s_valid = 1'b0;
    endtask

    task automatic send_packet(input data_word_t magic, input opcode_t op,
                               input bank_id_t first, input bank_id_t last_bank,
                               input word_addr_t start_addr, input word_addr_t count,
                               input bit gaps);
        drive_beat(magic, 1'b0, gaps);
        drive_beat(data_word_t'(op), 1'b0, gaps);
        drive_beat(data_word_t'(first), 1'b0, gaps);
        drive_beat(data_word_t'(last_bank), 1'b0, gaps);
        drive_beat(start_addr, 1'b0, gaps);
        drive_beat(count, 1'b0, gaps);
        for (int i = 0; i < payload_q.size(); i++) begin
            drive_beat(payload_q[i], i == payload_q.size() - 1, gaps);
        end
    endtask

    task automatic run_packet(input data_word_t magic, input opcode_t op,
                              input bank_id_t first, input bank_id_t last_bank,
                              input word_addr_t start_addr, input word_addr_t count,
                              input int n_words, input bit gaps, input string tag);
        loader_status_t exp;
        fill_payload(n_words);
        model_scatter(magic, op, first, last_bank, start_addr, count, exp);
        send_packet(magic, op, first, last_bank, start_addr, count, gaps);
        // packet_done is visible for exactly this cycle
        check_status(status, exp, tag);
        check_state(parser_state, HEADER_0, tag);
    endtask

    // One read per cycle with data sampled a cycle after the request
    task automatic verify_bank(input bank_id_t bank);
        @(negedge aclk);
        for (int a = 0; a < BANK_DEPTH; a++) begin
            rd_en   = 1'b1;
            rd_bank = bank;
            rd_addr = bank_addr_t'(a);
            @(negedge aclk);
            check_word(rd_data, shadow[bank][a], $sformatf("bank %0d addr %0d", bank, a));
        end
        rd_en = 1'b0;
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        if (errors > start_errors) begin
            tests_failed++;
            $display("test %s: FAIL (%0d errors)", name, errors - start_errors);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic test_reset();
        int start;
        start = errors;
        check_state(parser_state, HEADER_0, "reset");
        check_status(status, '0, "reset");
        if (s_ready !== 1'b1) begin
            $display("** Error at %0t: s_ready is %b after reset, expected 1", $time, s_ready);
            errors++;
        end
        report_test("reset", start);
    endtask

    task automatic test_single_bank();
        int start;
        start = errors;
        run_packet(HEADER_MAGIC, OP_LOAD, 5'd3, 5'd3, 16'd5, 16'd10, 10, 1'b0, "single bank");
        verify_bank(5'd3);
        report_test("single_bank_load", start);
    endtask

    task automatic test_multi_bank();
        int start;
        start = errors;
        run_packet(HEADER_MAGIC, OP_LOAD, 5'd2, 5'd4, 16'd62, 16'd4, 12, 1'b0, "multi bank");
        for (int b = 2; b <= 4; b++) verify_bank(bank_id_t'(b));
        report_test("multi_bank_spill", start);
    endtask

    task automatic test_bad_magic();
        int start;
        start = errors;
        // Same target as the single bank load, must leave it untouched
        run_packet(16'hBAD0, OP_LOAD, 5'd3, 5'd3, 16'd5, 16'd10, 8, 1'b0, "bad magic");
        verify_bank(5'd3);
        run_packet(HEADER_MAGIC, OP_LOAD, 5'd5, 5'd5, 16'd0, 16'd8, 8, 1'b0, "after bad magic");
        verify_bank(5'd5);
        report_test("bad_magic", start);
    endtask

    task automatic test_bad_opcode();
        int start;
        start = errors;
        run_packet(HEADER_MAGIC, 8'h07, 5'd2, 5'd2, 16'd62, 16'd4, 8, 1'b0, "bad opcode");
        verify_bank(5'd2);
        report_test("unknown_opcode", start);
    endtask

    task automatic test_overflow();
        int start;
        start = errors;
        run_packet(HEADER_MAGIC, OP_LOAD, 5'd6, 5'd7, 16'd30, 16'd5, 14, 1'b0, "overflow");
        verify_bank(5'd6);
        verify_bank(5'd7);
        report_test("overflow", start);
    endtask

    task automatic test_random_gaps();
        int start;
        start = errors;
        run_packet(HEADER_MAGIC, OP_LOAD, 5'd8, 5'd9, 16'd10, 16'd6, 12, 1'b1, "gaps 1");
        run_packet(HEADER_MAGIC, OP_LOAD, 5'd10, 5'd10, 16'd50, 16'd20, 20, 1'b1, "gaps 2");
        run_packet(HEADER_MAGIC, OP_LOAD, 5'd1, 5'd3, 16'd20, 16'd3, 9, 1'b1, "gaps 3");
        for (int b = 1; b <= 3; b++) verify_bank(bank_id_t'(b));
        for (int b = 8; b <= 10; b++) verify_bank(bank_id_t'(b));
        report_test("random_valid_gaps", start);
    endtask

    initial begin
        aresetn = 1'b0;
        s_valid = 1'b0;
        s_beat  = '0;
        rd_en   = 1'b0;
        rd_bank = '0;
        rd_addr = '0;
        repeat (8) @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);

        test_reset();
        test_single_bank();
        test_multi_bank();
        test_bad_magic();
        test_bad_opcode();
        test_overflow();
        test_random_gaps();

        $display("%0d tests run, %0d failing, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge aclk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bram_loader_top.f
source/bram_loader_pkg.sv
source/axi_header_parser.sv
source/bank_write_ctrl.sv
source/bram_bank_array.sv
source/bram_loader_top.sv
dv/bram_loader_tb.sv

//--- Bender.yml
package:
  name: bram_loader

sources:
  # RTL in compile order
  - files:
      - source/bram_loader_pkg.sv
      - source/axi_header_parser.sv
      - source/bank_write_ctrl.sv
      - source/bram_bank_array.sv
      - source/bram_loader_top.sv

  - target: test
    files:
      - dv/bram_loader_tb.sv
